// ==== verilog/core_isa_pkg.sv ====
/* ISA encodings shared by the pipeline stages of the core
   word and register index types, major opcodes, ALU operations, instruction classes */
package core_isa_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // add must stay the zero encoding
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // what execute does with the ALU result
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH_EQ,
        CLS_BRANCH_NE,
        CLS_JUMP
    } instr_class_e;

endpackage

// ==== verilog/core_pipe_pkg.sv ====
/* Stage-to-stage records of the core pipeline
   each struct is the payload of one pipeline register or request */
package core_pipe_pkg;

    // instruction word paired with its fetch address
    typedef struct packed {
        logic                valid;
        core_isa_pkg::word_t pc;
        core_isa_pkg::word_t instr;
    } fetch_to_decode_t;

    // fully decoded slot, operands already resolved
    typedef struct packed {
        logic                       valid;
        core_isa_pkg::instr_class_e cls;
        core_isa_pkg::alu_op_e      alu_op;
        core_isa_pkg::word_t        op_a;
        core_isa_pkg::word_t        op_b;
        core_isa_pkg::word_t        store_data;
        core_isa_pkg::reg_addr_t    rd;
        logic                       we;
        core_isa_pkg::word_t        target;
    } decode_to_exec_t;

    // result slot, also the forwarding copy
    typedef struct packed {
        logic                    valid;
        logic                    load;
        core_isa_pkg::reg_addr_t rd;
        logic                    we;
        core_isa_pkg::word_t     result;
    } exec_to_retire_t;

    // data memory request, word aligned
    typedef struct packed {
        logic                re;
        logic [3:0]          we;
        core_isa_pkg::word_t addr;
        core_isa_pkg::word_t wdata;
    } mem_req_t;

endpackage

// ==== verilog/fetch_stage.sv ====
/* Program counter and instruction register of the core
   pairs each word from the synchronous instruction memory with its address */
`timescale 1ns/1ps

module fetch_stage #(
    parameter core_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            enable_i,
    input  logic                            flush_i,
    input  logic                            redirect_i,
    input  core_isa_pkg::word_t             redirect_target_i,
    input  core_isa_pkg::word_t             instruction_i,
    output core_isa_pkg::word_t             instruction_address_o,
    output core_pipe_pkg::fetch_to_decode_t to_decode_o
);

    core_isa_pkg::word_t pc_q;
    // address of the word now arriving on instruction_i
    core_isa_pkg::word_t pc_dec_q;
    logic                valid_q;
    // instruction register, used while fetch is held
    core_isa_pkg::word_t instr_q;
    logic                held_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_q     <= RESET_PC;
            pc_dec_q <= RESET_PC;
            valid_q  <= 1'b0;
            held_q   <= 1'b0;
        end else begin
            held_q <= !enable_i;
            if (enable_i) begin
                pc_dec_q <= pc_q;
                valid_q  <= 1'b1;
                // taken branch or jump restarts at the target
                if (redirect_i)
                    pc_q <= redirect_target_i;
                else
                    pc_q <= pc_q + 32'd4;
            end
        end
    end

    // memory keeps reading pc_q, so catch the word on the first held cycle
    always_ff @(posedge clk) begin
        if (!enable_i && !held_q)
            instr_q <= instruction_i;
    end

    assign instruction_address_o = pc_q;
    assign to_decode_o.valid     = valid_q && !flush_i;
    assign to_decode_o.pc        = pc_dec_q;
    assign to_decode_o.instr     = held_q ? instr_q : instruction_i;

endmodule

// ==== verilog/decode_stage.sv ====
/* Decode stage of the core
   field decode, immediates, operand forwarding and the decode-to-execute register */
`timescale 1ns/1ps

module decode_stage (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            enable_i,
    input  logic                            bubble_i,
    input  logic                            flush_i,
    input  core_pipe_pkg::fetch_to_decode_t from_fetch_i,
    input  core_isa_pkg::word_t             rs1_data_i,
    input  core_isa_pkg::word_t             rs2_data_i,
    input  core_pipe_pkg::exec_to_retire_t  fwd_i,
    output core_isa_pkg::reg_addr_t         rs1_o,
    output core_isa_pkg::reg_addr_t         rs2_o,
    output core_pipe_pkg::decode_to_exec_t  to_exec_o
);

    core_isa_pkg::word_t            instr;
    core_isa_pkg::opcode_e          opcode;
    core_isa_pkg::word_t            imm_i;
    core_isa_pkg::word_t            imm_s;
    core_isa_pkg::word_t            imm_b;
    core_isa_pkg::word_t            imm_u;
    core_isa_pkg::word_t            imm_j;
    core_isa_pkg::word_t            rs1_val;
    core_isa_pkg::word_t            rs2_val;
    logic                           known;
    core_pipe_pkg::decode_to_exec_t dec;

    // execute result wins over the bank, loads are not ready yet
    function automatic core_isa_pkg::word_t fwd_sel(core_isa_pkg::reg_addr_t rs,
                                                    core_isa_pkg::word_t bank);
        if (fwd_i.valid && fwd_i.we && !fwd_i.load && fwd_i.rd == rs)
            return fwd_i.result;
        return bank;
    endfunction

    assign instr   = from_fetch_i.instr;
    assign opcode  = core_isa_pkg::opcode_e'(instr[6:0]);
    assign rs1_o   = instr[19:15];
    assign rs2_o   = instr[24:20];
    assign rs1_val = fwd_sel(rs1_o, rs1_data_i);
    assign rs2_val = fwd_sel(rs2_o, rs2_data_i);

    ////////////////////
    // immediates
    ////////////////////
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////
    // opcode decode
    ////////////////////
    always_comb begin
        known          = 1'b1;
        // zero gives class ALU with an add
        dec            = '0;
        dec.op_a       = rs1_val;
        dec.op_b       = rs2_val;
        dec.store_data = rs2_val;
        dec.rd         = instr[11:7];
        dec.target     = from_fetch_i.pc + imm_b;
        case (opcode)
            core_isa_pkg::OPC_OP: begin
                dec.we = 1'b1;
                case (instr[14:12])
                    3'b000:  dec.alu_op = instr[30] ? core_isa_pkg::ALU_SUB : core_isa_pkg::ALU_ADD;
                    3'b100:  dec.alu_op = core_isa_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = core_isa_pkg::ALU_OR;
                    3'b111:  dec.alu_op = core_isa_pkg::ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            core_isa_pkg::OPC_OP_IMM: begin
                // addi only
                dec.we   = 1'b1;
                dec.op_b = imm_i;
                known    = instr[14:12] == 3'b000;
            end
            core_isa_pkg::OPC_LUI: begin
                dec.we     = 1'b1;
                dec.alu_op = core_isa_pkg::ALU_PASS_B;
                dec.op_b   = imm_u;
            end
            core_isa_pkg::OPC_LOAD: begin
                dec.cls  = core_isa_pkg::CLS_LOAD;
                dec.we   = 1'b1;
                dec.op_b = imm_i;
            end
            core_isa_pkg::OPC_STORE: begin
                dec.cls  = core_isa_pkg::CLS_STORE;
                dec.op_b = imm_s;
            end
            core_isa_pkg::OPC_BRANCH: begin
                // equality from a subtract
                dec.alu_op = core_isa_pkg::ALU_SUB;
                case (instr[14:12])
                    3'b000:  dec.cls = core_isa_pkg::CLS_BRANCH_EQ;
                    3'b001:  dec.cls = core_isa_pkg::CLS_BRANCH_NE;
                    default: known = 1'b0;
                endcase
            end
            core_isa_pkg::OPC_JAL: begin
                // link value is pc plus 4
                dec.cls    = core_isa_pkg::CLS_JUMP;
                dec.we     = 1'b1;
                dec.op_a   = from_fetch_i.pc;
                dec.op_b   = 32'd4;
                dec.target = from_fetch_i.pc + imm_j;
            end
            default: known = 1'b0;
        endcase
        // x0 is never a destination
        dec.we    = dec.we && dec.rd != '0;
        dec.valid = from_fetch_i.valid && known;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            to_exec_o <= '0;
        end else if (enable_i) begin
            to_exec_o <= dec;
            // empty execute slot on load-use or kill
            if (bubble_i || flush_i)
                to_exec_o.valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/register_bank.sv ====
/* Integer register file, two asynchronous read ports and one write port
   x0 reads as zero and a same-cycle write is bypassed to the readers */
`timescale 1ns/1ps

module register_bank (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    we_i,
    input  core_isa_pkg::reg_addr_t rd_i,
    input  core_isa_pkg::word_t     wdata_i,
    input  core_isa_pkg::reg_addr_t rs1_i,
    input  core_isa_pkg::reg_addr_t rs2_i,
    output core_isa_pkg::word_t     rs1_data_o,
    output core_isa_pkg::word_t     rs2_data_o
);

    // x1 to x31 only
    core_isa_pkg::word_t regs [31:1];

    function automatic core_isa_pkg::word_t read_port(core_isa_pkg::reg_addr_t rs);
        if (rs == '0)
            return '0;
        if (we_i && rd_i == rs)
            return wdata_i;
        return regs[rs];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = read_port(rs1_i);
    assign rs2_data_o = read_port(rs2_i);

endmodule

// ==== verilog/execute_stage.sv ====
/* Execute and retire stages of the core
   ALU, branch resolution, data memory request and the load writeback select */
`timescale 1ns/1ps

module execute_stage (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           enable_i,
    input  core_pipe_pkg::decode_to_exec_t from_decode_i,
    input  core_isa_pkg::word_t            mem_data_i,
    output core_pipe_pkg::mem_req_t        mem_req_o,
    output logic                           redirect_o,
    output core_isa_pkg::word_t            redirect_target_o,
    output logic                           is_load_o,
    output core_isa_pkg::reg_addr_t        rd_o,
    output core_pipe_pkg::exec_to_retire_t fwd_o,
    output core_pipe_pkg::exec_to_retire_t retire_o,
    output core_isa_pkg::word_t            wb_data_o
);

    core_isa_pkg::word_t result;
    logic                taken;
    logic                is_store;

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (from_decode_i.alu_op)
            core_isa_pkg::ALU_ADD:    result = from_decode_i.op_a + from_decode_i.op_b;
            core_isa_pkg::ALU_SUB:    result = from_decode_i.op_a - from_decode_i.op_b;
            core_isa_pkg::ALU_AND:    result = from_decode_i.op_a & from_decode_i.op_b;
            core_isa_pkg::ALU_OR:     result = from_decode_i.op_a | from_decode_i.op_b;
            core_isa_pkg::ALU_XOR:    result = from_decode_i.op_a ^ from_decode_i.op_b;
            core_isa_pkg::ALU_PASS_B: result = from_decode_i.op_b;
            default:                  result = '0;
        endcase
    end

    // branches compare through the subtract
    always_comb begin
        case (from_decode_i.cls)
            core_isa_pkg::CLS_BRANCH_EQ: taken = result == '0;
            core_isa_pkg::CLS_BRANCH_NE: taken = result != '0;
            core_isa_pkg::CLS_JUMP:      taken = 1'b1;
            default:                     taken = 1'b0;
        endcase
    end

    assign redirect_o        = from_decode_i.valid && taken;
    assign redirect_target_o = from_decode_i.target;

    ////////////////////
    // memory request
    ////////////////////
    assign is_load_o = from_decode_i.valid && from_decode_i.cls == core_isa_pkg::CLS_LOAD;
    assign is_store  = from_decode_i.valid && from_decode_i.cls == core_isa_pkg::CLS_STORE;
    assign rd_o      = from_decode_i.rd;

    always_comb begin
        mem_req_o.re    = is_load_o;
        // word stores only
        mem_req_o.we    = {4{is_store}};
        mem_req_o.addr  = {result[31:2], 2'b00};
        mem_req_o.wdata = from_decode_i.store_data;
    end

    // forwarding copy, decode reads it in the same cycle
    always_comb begin
        fwd_o.valid  = from_decode_i.valid;
        fwd_o.load   = from_decode_i.cls == core_isa_pkg::CLS_LOAD;
        fwd_o.rd     = from_decode_i.rd;
        fwd_o.we     = from_decode_i.we;
        fwd_o.result = result;
    end

    ////////////////////
    // retire
    ////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            retire_o <= '0;
        else if (enable_i)
            retire_o <= fwd_o;
        else
            // load data is only on the bus once, so write back once and drop the slot
            retire_o.valid <= 1'b0;
    end

    assign wb_data_o = retire_o.load ? mem_data_i : retire_o.result;

    // store leaves no register write behind it
    assert property (@(posedge clk) disable iff (!reset_n)
        (enable_i && mem_req_o.we != '0) |-> !mem_req_o.re ##1 !(retire_o.valid && retire_o.we));

endmodule

// ==== verilog/pipeline_control.sv ====
/* Hazard and flush control of the core pipeline
   load-use bubble, two-cycle kill after a redirect, and the stage enables */
`timescale 1ns/1ps

module pipeline_control (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    stall_i,
    input  core_isa_pkg::reg_addr_t decode_rs1_i,
    input  core_isa_pkg::reg_addr_t decode_rs2_i,
    input  logic                    exec_is_load_i,
    input  core_isa_pkg::reg_addr_t exec_rd_i,
    input  logic                    redirect_i,
    output logic                    fetch_en_o,
    output logic                    decode_en_o,
    output logic                    bubble_o,
    output logic                    flush_o
);

    typedef enum logic {
        RUN,
        FLUSH
    } flush_state_e;

    flush_state_e state_q;

    // load result not ready for the reader in decode
    assign bubble_o = exec_is_load_i && exec_rd_i != '0 &&
                      (decode_rs1_i == exec_rd_i || decode_rs2_i == exec_rd_i);

    // FLUSH kills the word fetched before the target
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state_q <= RUN;
        else if (!stall_i)
            state_q <= (state_q == RUN && redirect_i) ? FLUSH : RUN;
    end

    assign flush_o     = redirect_i || state_q == FLUSH;
    assign fetch_en_o  = !stall_i && !bubble_o;
    assign decode_en_o = !stall_i;

    // a hold and a kill of fetch together would lose the restart
    assert property (@(posedge clk) disable iff (!reset_n) !(bubble_o && flush_o));

endmodule

// ==== verilog/rs_core.sv ====
/* Top level of the five-block RISC-V integer core
   connects the stages and drives the instruction and data memory ports */
`timescale 1ns/1ps

module rs_core #(
    parameter core_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  core_isa_pkg::word_t instruction_i,
    input  core_isa_pkg::word_t mem_data_i,
    output core_isa_pkg::word_t instruction_address_o,
    output logic                mem_operation_enable_o,
    output logic [3:0]          mem_write_enable_o,
    output core_isa_pkg::word_t mem_address_o,
    output core_isa_pkg::word_t mem_data_o
);

    core_pipe_pkg::fetch_to_decode_t f2d;
    core_pipe_pkg::decode_to_exec_t  d2e;
    core_pipe_pkg::exec_to_retire_t  fwd;
    core_pipe_pkg::exec_to_retire_t  retire;
    core_pipe_pkg::mem_req_t         mem_req;

    core_isa_pkg::reg_addr_t rs1;
    core_isa_pkg::reg_addr_t rs2;
    core_isa_pkg::reg_addr_t exec_rd;
    core_isa_pkg::word_t     rs1_data;
    core_isa_pkg::word_t     rs2_data;
    core_isa_pkg::word_t     wb_data;
    core_isa_pkg::word_t     redirect_target;

    logic fetch_en;
    logic decode_en;
    logic bubble;
    logic flush;
    logic redirect;
    logic exec_is_load;

    ////////////////////
    // stages
    ////////////////////
    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .clk                  (clk),
        .reset_n              (reset_n),
        .enable_i             (fetch_en),
        .flush_i              (flush),
        .redirect_i           (redirect),
        .redirect_target_i    (redirect_target),
        .instruction_i        (instruction_i),
        .instruction_address_o(instruction_address_o),
        .to_decode_o          (f2d)
    );

    decode_stage decode_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (decode_en),
        .bubble_i    (bubble),
        .flush_i     (flush),
        .from_fetch_i(f2d),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .fwd_i       (fwd),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .to_exec_o   (d2e)
    );

    // retire slot writes the bank
    register_bank regbank_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .we_i      (retire.valid && retire.we),
        .rd_i      (retire.rd),
        .wdata_i   (wb_data),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    execute_stage execute_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (decode_en),
        .from_decode_i    (d2e),
        .mem_data_i       (mem_data_i),
        .mem_req_o        (mem_req),
        .redirect_o       (redirect),
        .redirect_target_o(redirect_target),
        .is_load_o        (exec_is_load),
        .rd_o             (exec_rd),
        .fwd_o            (fwd),
        .retire_o         (retire),
        .wb_data_o        (wb_data)
    );

    pipeline_control control_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .stall_i       (stall_i),
        .decode_rs1_i  (rs1),
        .decode_rs2_i  (rs2),
        .exec_is_load_i(exec_is_load),
        .exec_rd_i     (exec_rd),
        .redirect_i    (redirect),
        .fetch_en_o    (fetch_en),
        .decode_en_o   (decode_en),
        .bubble_o      (bubble),
        .flush_o       (flush)
    );

    ////////////////////
    // data memory port
    ////////////////////
    // execute holds during a stall, so the request must not repeat
    assign mem_operation_enable_o = (mem_req.re || mem_req.we != '0) && !stall_i;
    assign mem_write_enable_o     = stall_i ? 4'b0000 : mem_req.we;
    assign mem_address_o          = mem_req.addr;
    assign mem_data_o             = mem_req.wdata;

endmodule

// ==== sim/core_checker.sv ====
/* Store monitor for the core testbench
   compares each data memory write of the DUT with the expected store list */
`timescale 1ns/1ps

module core_checker #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] instruction_address_i,
    input  logic        mem_operation_enable_i,
    input  logic [3:0]  mem_write_enable_i,
    input  logic [31:0] mem_address_i,
    input  logic [31:0] mem_data_i,
    output int          store_count_o,
    output int          error_count_o
);

    // expected stores of the running test, in program order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    initial begin
        store_count_o = 0;
        error_count_o = 0;
    end

    task automatic clear_expected();
        exp_addr.delete();
        exp_data.delete();
        store_count_o = 0;
    endtask

    task automatic add_expected(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            // idle core, fetch parked at the reset address
            if (instruction_address_i != RESET_PC || mem_operation_enable_i ||
                mem_write_enable_i != 4'b0000) begin
                $display("core not idle during reset at %0t ns", $time);
                error_count_o = error_count_o + 1;
            end
        end else if (mem_operation_enable_i && mem_write_enable_i != 4'b0000) begin
            if (store_count_o >= exp_addr.size()) begin
                $display("store to %h at %0t ns is beyond the expected list",
                         mem_address_i, $time);
                error_count_o = error_count_o + 1;
            end else if (mem_write_enable_i != 4'b1111 ||
                         mem_address_i != exp_addr[store_count_o] ||
                         mem_data_i != exp_data[store_count_o]) begin
                $display("Mismatch at %0t ns: store %0d expected [%h]=%h, got [%h]=%h be %b",
                         $time, store_count_o, exp_addr[store_count_o],
                         exp_data[store_count_o], mem_address_i, mem_data_i,
                         mem_write_enable_i);
                error_count_o = error_count_o + 1;
            end
            store_count_o = store_count_o + 1;
        end
    end

endmodule

// ==== sim/core_tb.sv ====
/* Testbench of the core, runs a table of small programs against memory models
   each test resets the DUT, loads its program and data, and waits for the stores */
`timescale 1ns/1ps

module core_tb;

    localparam logic [31:0] RESET_PC = 32'h0;
    localparam int          NT       = 8;

    logic        clk;
    logic        reset_n;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] mem_data_i;
    logic [31:0] instruction_address_o;
    logic        mem_operation_enable_o;
    logic [3:0]  mem_write_enable_o;
    logic [31:0] mem_address_o;
    logic [31:0] mem_data_o;
    int          store_count;
    int          error_count;

    // test table
    logic [31:0] prog [NT][12];
    logic [31:0] img_addr [NT][2];
    logic [31:0] img_data [NT][2];
    logic [31:0] exp_addr [NT][4];
    logic [31:0] exp_data [NT][4];
    int          exp_n [NT];
    logic        use_stall [NT];
    int          cur;
    int          pn;

    // memory models
    logic [31:0] imem [16];
    logic [31:0] dmem [64];
    logic        stall_on;

    rs_core #(.RESET_PC(RESET_PC)) dut_i (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i),
        .instruction_i(instruction_i), .mem_data_i(mem_data_i),
        .instruction_address_o(instruction_address_o),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o(mem_write_enable_o),
        .mem_address_o(mem_address_o), .mem_data_o(mem_data_o)
    );

    core_checker #(.RESET_PC(RESET_PC)) check_i (
        .clk(clk), .reset_n(reset_n), .instruction_address_i(instruction_address_o),
        .mem_operation_enable_i(mem_operation_enable_o),
        .mem_write_enable_i(mem_write_enable_o), .mem_address_i(mem_address_o),
        .mem_data_i(mem_data_o), .store_count_o(store_count), .error_count_o(error_count)
    );

    always #50 clk = ~clk;

    // synchronous memories answer one cycle later
    always @(posedge clk) begin
        instruction_i <= imem[instruction_address_o[5:2]];
        if (mem_operation_enable_o && mem_write_enable_o != 4'b0000)
            dmem[mem_address_o[7:2]] <= mem_data_o;
        else if (mem_operation_enable_o)
            mem_data_i <= dmem[mem_address_o[7:2]];
        stall_i <= stall_on && reset_n && ($urandom % 3 == 0);
    end

    ////////////////////
    // RV32I encoders
    ////////////////////
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[cur][pn] = w;
        pn++;
    endtask

    task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
        exp_addr[cur][exp_n[cur]] = a;
        exp_data[cur][exp_n[cur]] = d;
        exp_n[cur]++;
    endtask

    task automatic begin_test(input int t);
        cur = t;
        pn  = 0;
        // self jump fills the rest of the program
        for (int i = 0; i < 12; i++)
            prog[t][i] = enc_j(0, 0);
    endtask

    task automatic build_table();
        for (int t = 0; t < NT; t++) begin
            exp_n[t]     = 0;
            use_stall[t] = 1'b0;
            img_addr[t]  = '{32'h100, 32'h104};
            img_data[t]  = '{32'h0, 32'h0};
        end
        // alu chain with forwarding
        begin_test(0);
        emit({20'h12345, 5'd1, 7'b0110111});
        emit(enc_i('h678, 1, 0, 2, 'b0010011));
        emit(enc_i(-1, 0, 0, 3, 'b0010011));
        emit(enc_r(0, 3, 2, 'b100, 4));
        emit(enc_r('h20, 1, 2, 0, 5));
        emit(enc_r(0, 3, 2, 'b111, 6));
        emit(enc_r(0, 5, 4, 'b110, 7));
        emit(enc_r(0, 6, 7, 0, 8));
        emit(enc_s('h100, 8, 0));
        emit(enc_s('h104, 5, 0));
        emit(enc_s('h108, 4, 0));
        expect_store(32'h100, (~32'h12345678 | 32'h678) + 32'h12345678);
        expect_store(32'h104, 32'h678);
        expect_store(32'h108, ~32'h12345678);
        // load-use
        begin_test(1);
        img_data[1] = '{32'h00001111, 32'h20000000};
        emit(enc_i('h100, 0, 'b010, 1, 'b0000011));
        emit(enc_i(5, 1, 0, 2, 'b0010011));
        emit(enc_s('h110, 2, 0));
        emit(enc_i('h104, 0, 'b010, 3, 'b0000011));
        emit(enc_s('h114, 3, 0));
        emit(enc_i('h100, 0, 'b010, 4, 'b0000011));
        emit(enc_r(0, 3, 4, 0, 5));
        emit(enc_s('h118, 5, 0));
        expect_store(32'h110, 32'h00001116);
        expect_store(32'h114, 32'h20000000);
        expect_store(32'h118, 32'h20001111);
        // beq taken, bne not taken, jal with link
        begin_test(2);
        emit(enc_i(7, 0, 0, 1, 'b0010011));
        emit(enc_i(7, 0, 0, 2, 'b0010011));
        emit(enc_b(12, 2, 1, 'b000));
        emit(enc_s('h120, 1, 0));
        emit(enc_s('h124, 2, 0));
        emit(enc_b(8, 2, 1, 'b001));
        emit(enc_s('h128, 1, 0));
        emit(enc_j(12, 3));
        emit(enc_s('h12c, 0, 0));
        emit(enc_s('h130, 0, 0));
        emit(enc_s('h12c, 3, 0));
        expect_store(32'h128, 32'd7);
        expect_store(32'h12c, 32'd28 + 32'd4);
        // beq not taken, bne taken
        begin_test(3);
        emit(enc_i(3, 0, 0, 1, 'b0010011));
        emit(enc_i(4, 0, 0, 2, 'b0010011));
        emit(enc_b(12, 2, 1, 'b000));
        emit(enc_s('h140, 1, 0));
        emit(enc_b(12, 2, 1, 'b001));
        emit(enc_s('h144, 2, 0));
        emit(enc_s('h148, 2, 0));
        emit(enc_r(0, 2, 1, 0, 3));
        emit(enc_s('h14c, 3, 0));
        expect_store(32'h140, 32'd3);
        expect_store(32'h14c, 32'd7);
        // same programs again under random stall
        for (int t = 4; t < NT; t++) begin
            prog[t]      = prog[t-4];
            img_data[t]  = img_data[t-4];
            exp_addr[t]  = exp_addr[t-4];
            exp_data[t]  = exp_data[t-4];
            exp_n[t]     = exp_n[t-4];
            use_stall[t] = 1'b1;
        end
    endtask

    ////////////////////
    // test loop
    ////////////////////
    initial begin
        int passed;
        int failed;
        int cycles;
        int errs_before;
        logic ok;
        clk           = 1'b0;
        reset_n       = 1'b0;
        stall_i       = 1'b0;
        stall_on      = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        passed        = 0;
        failed        = 0;
        void'($urandom(32'h25da));
        build_table();
        for (int t = 0; t < NT; t++) begin
            errs_before = error_count;
            @(posedge clk);
            reset_n  <= 1'b0;
            stall_on <= 1'b0;
            // image over an address-dependent fill
            for (int i = 0; i < 64; i++)
                dmem[i] = 32'hd00d0000 ^ (32'h100 + 32'(i) * 32'd4);
            for (int i = 0; i < 2; i++)
                dmem[img_addr[t][i][7:2]] = img_data[t][i];
            for (int i = 0; i < 16; i++)
                imem[i] = (i < 12) ? prog[t][i] : enc_j(0, 0);
            check_i.clear_expected();
            for (int i = 0; i < exp_n[t]; i++)
                check_i.add_expected(exp_addr[t][i], exp_data[t][i]);
            repeat (16) @(posedge clk);
            reset_n  <= 1'b1;
            stall_on <= use_stall[t];
            ok       = 1'b1;
            cycles   = 0;
            while (store_count < exp_n[t] && cycles < 400) begin
                @(negedge clk);
                cycles++;
            end
            if (store_count < exp_n[t]) begin
                $display("test %0d timed out with %0d of %0d stores", t, store_count,
                         exp_n[t]);
                ok = 1'b0;
            end
            // drain, program sits in its self jump, no further store allowed
            cycles = 0;
            while (cycles < 40) begin
                @(negedge clk);
                cycles++;
            end
            if (error_count != errs_before)
                ok = 1'b0;
            if (ok) begin
                passed++;
                $display("test %0d (stall %0d) passed", t, use_stall[t]);
            end else begin
                failed++;
                $display("test %0d (stall %0d) failed", t, use_stall[t]);
            end
        end
        $display("tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/core_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_bank.sv
verilog/execute_stage.sv
verilog/pipeline_control.sv
verilog/rs_core.sv
sim/core_checker.sv
sim/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f filelist.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
